//--- sd_pkg.sv
`default_nettype none

package sd_pkg;

    // AXI4-Lite slave geometry
    localparam int AXI_ADDR_W = 7;
    localparam int AXI_DATA_W = 32;

    // register map
    localparam logic [AXI_ADDR_W-1:0] REG_ARGUMENT   = 7'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_COMMAND    = 7'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_RESPONSE   = 7'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_INT_STATUS = 7'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_INT_ENABLE = 7'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_CLK_DIV    = 7'h14;
    localparam logic [AXI_ADDR_W-1:0] REG_PRESENT    = 7'h18;
    localparam logic [AXI_ADDR_W-1:0] REG_TIMEOUT    = 7'h1C;

    // command register fields
    localparam int CMD_INDEX_W = 6;
    localparam int RESP_EN_BIT = 8;

    localparam int CMD_FRAME_W   = 48;
    localparam int CRC7_W        = 7;
    localparam int CLK_DIV_W     = 8;
    localparam int CMD_TIMEOUT_W = 16;

    // command interrupt bits
    localparam int INT_CMD_W       = 4;
    localparam int INT_CMD_DONE    = 0;
    localparam int INT_CMD_TIMEOUT = 1;
    localparam int INT_CMD_CRC     = 2;
    localparam int INT_CMD_INDEX   = 3;

    // SD CRC7, x^7 + x^3 + 1, zero seed, over the 40 header bits
    function automatic logic [CRC7_W-1:0] crc7(input logic [CMD_FRAME_W-9:0] data);
        logic [CRC7_W-1:0] crc;
        logic fb;
        crc = '0;
        for (int i = CMD_FRAME_W - 9; i >= 0; i--) begin
            fb = data[i] ^ crc[CRC7_W-1];
            crc = {crc[CRC7_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

//--- sd_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sd_axil_regs (
    input  wire                                  s00_axi_aclk,
    input  wire                                  reset_i,
    input  wire [sd_pkg::AXI_ADDR_W-1:0]         s00_axi_awaddr_i,
    input  wire                                  s00_axi_awvalid_i,
    output logic                                 s00_axi_awready_o,
    input  wire [sd_pkg::AXI_DATA_W-1:0]         s00_axi_wdata_i,
    input  wire                                  s00_axi_wvalid_i,
    output logic                                 s00_axi_wready_o,
    output logic [1:0]                           s00_axi_bresp_o,
    output logic                                 s00_axi_bvalid_o,
    input  wire                                  s00_axi_bready_i,
    input  wire [sd_pkg::AXI_ADDR_W-1:0]         s00_axi_araddr_i,
    input  wire                                  s00_axi_arvalid_i,
    output logic                                 s00_axi_arready_o,
    output logic [sd_pkg::AXI_DATA_W-1:0]        s00_axi_rdata_o,
    output logic [1:0]                           s00_axi_rresp_o,
    output logic                                 s00_axi_rvalid_o,
    input  wire                                  s00_axi_rready_i,
    output logic [sd_pkg::CLK_DIV_W-1:0]         clk_div_o,
    output logic [sd_pkg::AXI_DATA_W-1:0]        argument_o,
    output logic [sd_pkg::CMD_INDEX_W-1:0]       cmd_index_o,
    output logic                                 resp_en_o,
    output logic [sd_pkg::CMD_TIMEOUT_W-1:0]     timeout_o,
    output logic                                 cmd_start_o,
    output logic                                 interrupt_o,
    input  wire                                  cmd_inhibit_i,
    input  wire [sd_pkg::INT_CMD_W-1:0]          int_set_i,
    input  wire                                  response_we_i,
    input  wire [sd_pkg::AXI_DATA_W-1:0]         response_i
);

    logic [sd_pkg::AXI_ADDR_W-1:0] rd_addr;
    logic [sd_pkg::AXI_DATA_W-1:0] resp_r;
    logic [sd_pkg::INT_CMD_W-1:0]  status_r;
    logic [sd_pkg::INT_CMD_W-1:0]  enable_r;
    logic [sd_pkg::INT_CMD_W-1:0]  clr_bits;
    logic                          aw_accept;
    logic                          ar_accept;

    assign s00_axi_wready_o = s00_axi_awready_o;
    assign s00_axi_bresp_o  = 2'b00;
    assign s00_axi_rresp_o  = 2'b00;
    assign interrupt_o      = |(status_r & enable_r);

    // no new request while a response is still pending
    assign aw_accept = s00_axi_awvalid_i && s00_axi_wvalid_i && !s00_axi_awready_o
                       && !s00_axi_bvalid_o;
    assign ar_accept = s00_axi_arvalid_i && !s00_axi_arready_o && !s00_axi_rvalid_o;

    // write-one-to-clear mask
    assign clr_bits = (aw_accept && s00_axi_awaddr_i == sd_pkg::REG_INT_STATUS)
                      ? s00_axi_wdata_i[sd_pkg::INT_CMD_W-1:0] : '0;

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            s00_axi_awready_o <= 1'b0;
            s00_axi_bvalid_o  <= 1'b0;
            argument_o        <= '0;
            cmd_index_o       <= '0;
            resp_en_o         <= 1'b0;
            cmd_start_o       <= 1'b0;
            enable_r          <= '0;
            clk_div_o         <= '0;
            timeout_o         <= '0;
            status_r          <= '0;
            resp_r            <= '0;
        end else begin
            s00_axi_awready_o <= aw_accept;
            cmd_start_o       <= 1'b0;
            if (s00_axi_awready_o) begin
                s00_axi_bvalid_o <= 1'b1;
            end else if (s00_axi_bvalid_o && s00_axi_bready_i) begin
                s00_axi_bvalid_o <= 1'b0;
            end
            if (aw_accept) begin
                case (s00_axi_awaddr_i)
                    sd_pkg::REG_ARGUMENT: argument_o <= s00_axi_wdata_i;
                    sd_pkg::REG_COMMAND: begin
                        if (!cmd_inhibit_i) begin
                            cmd_index_o <= s00_axi_wdata_i[sd_pkg::CMD_INDEX_W-1:0];
                            resp_en_o   <= s00_axi_wdata_i[sd_pkg::RESP_EN_BIT];
                            cmd_start_o <= 1'b1;
                        end
                    end
                    sd_pkg::REG_INT_ENABLE: enable_r <= s00_axi_wdata_i[sd_pkg::INT_CMD_W-1:0];
                    sd_pkg::REG_CLK_DIV: clk_div_o <= s00_axi_wdata_i[sd_pkg::CLK_DIV_W-1:0];
                    sd_pkg::REG_TIMEOUT:
                        timeout_o <= s00_axi_wdata_i[sd_pkg::CMD_TIMEOUT_W-1:0];
                    default: ;
                endcase
            end
            // a set in the same cycle wins over the clear
            status_r <= (status_r & ~clr_bits) | int_set_i;
            if (response_we_i) begin
                resp_r <= response_i;
            end
        end
    end

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            s00_axi_arready_o <= 1'b0;
            s00_axi_rvalid_o  <= 1'b0;
            s00_axi_rdata_o   <= '0;
            rd_addr           <= '0;
        end else begin
            s00_axi_arready_o <= ar_accept;
            if (ar_accept) begin
                rd_addr <= s00_axi_araddr_i;
            end
            if (s00_axi_arready_o) begin
                s00_axi_rvalid_o <= 1'b1;
                case (rd_addr)
                    sd_pkg::REG_ARGUMENT:   s00_axi_rdata_o <= argument_o;
                    sd_pkg::REG_COMMAND:
                        s00_axi_rdata_o <= (32'(resp_en_o) << sd_pkg::RESP_EN_BIT)
                                           | 32'(cmd_index_o);
                    sd_pkg::REG_RESPONSE:   s00_axi_rdata_o <= resp_r;
                    sd_pkg::REG_INT_STATUS: s00_axi_rdata_o <= 32'(status_r);
                    sd_pkg::REG_INT_ENABLE: s00_axi_rdata_o <= 32'(enable_r);
                    sd_pkg::REG_CLK_DIV:    s00_axi_rdata_o <= 32'(clk_div_o);
                    sd_pkg::REG_PRESENT:    s00_axi_rdata_o <= 32'(cmd_inhibit_i);
                    sd_pkg::REG_TIMEOUT:    s00_axi_rdata_o <= 32'(timeout_o);
                    default:                s00_axi_rdata_o <= '0;
                endcase
            end else if (s00_axi_rvalid_o && s00_axi_rready_i) begin
                s00_axi_rvalid_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sd_emmc_controller.sv
`timescale 1ns/1ps
`default_nettype none

// shifts one 48-bit command frame out, one bit per SD_CLK falling edge
module sd_cmd_tx (
    input  wire        s00_axi_aclk,
    input  wire        reset_i,
    input  wire        fall_evt_i,
    input  wire        start_i,
    input  wire [47:0] frame_i,
    output logic       sd_cmd_o,
    output logic       sd_cmd_t_o,
    output logic       done_o
);

    logic [47:0] sh;
    logic [5:0]  cnt;
    logic        active;

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            sd_cmd_o   <= 1'b1;
            sd_cmd_t_o <= 1'b0;
            active     <= 1'b0;
            done_o     <= 1'b0;
            cnt        <= '0;
            sh         <= '0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                sh     <= frame_i;
                cnt    <= '0;
                active <= 1'b1;
            end else if (active && fall_evt_i) begin
                if (cnt < 6'd48) begin
                    sd_cmd_o   <= sh[47];
                    sh         <= {sh[46:0], 1'b0};
                    sd_cmd_t_o <= 1'b1;
                    cnt        <= cnt + 6'd1;
                end else begin
                    sd_cmd_t_o <= 1'b0;
                    sd_cmd_o   <= 1'b1;
                    active     <= 1'b0;
                    done_o     <= 1'b1;
                end
            end
        end
    end

endmodule

module sd_emmc_controller (
    input  wire                           s00_axi_aclk,
    input  wire                           reset_i,
    input  wire [sd_pkg::AXI_ADDR_W-1:0]  s00_axi_awaddr_i,
    input  wire                           s00_axi_awvalid_i,
    output logic                          s00_axi_awready_o,
    input  wire [sd_pkg::AXI_DATA_W-1:0]  s00_axi_wdata_i,
    input  wire                           s00_axi_wvalid_i,
    output logic                          s00_axi_wready_o,
    output logic [1:0]                    s00_axi_bresp_o,
    output logic                          s00_axi_bvalid_o,
    input  wire                           s00_axi_bready_i,
    input  wire [sd_pkg::AXI_ADDR_W-1:0]  s00_axi_araddr_i,
    input  wire                           s00_axi_arvalid_i,
    output logic                          s00_axi_arready_o,
    output logic [sd_pkg::AXI_DATA_W-1:0] s00_axi_rdata_o,
    output logic [1:0]                    s00_axi_rresp_o,
    output logic                          s00_axi_rvalid_o,
    input  wire                           s00_axi_rready_i,
    output logic                          sd_clk_o,
    output logic                          sd_cmd_o,
    output logic                          sd_cmd_t_o,
    input  wire                           sd_cmd_i,
    output logic                          interrupt_o
);

    typedef enum logic [2:0] {S_IDLE, S_TX, S_RX_WAIT, S_RX, S_CHECK} state_t;

    logic [sd_pkg::CLK_DIV_W-1:0]     div_r;
    logic [31:0]                      arg_r;
    logic [sd_pkg::CMD_INDEX_W-1:0]   idx_r;
    logic                             resp_en_r;
    logic [sd_pkg::CMD_TIMEOUT_W-1:0] timeout_r;
    logic                             cmd_start;
    logic                             cmd_inhibit;
    logic [sd_pkg::INT_CMD_W-1:0]     int_set;
    logic                             response_we;
    logic [31:0]                      response;

    logic [sd_pkg::CLK_DIV_W-1:0] div_cnt;
    logic rise_evt, fall_evt;

    state_t      state;
    logic        tx_start, tx_done;
    logic [47:0] tx_frame;
    logic [47:0] rx_sh;
    logic [5:0]  rcnt;
    logic [sd_pkg::CMD_TIMEOUT_W-1:0] tcnt;

    assign cmd_inhibit = (state != S_IDLE) || cmd_start;

    sd_axil_regs u_regs (
        .s00_axi_aclk      (s00_axi_aclk),
        .reset_i           (reset_i),
        .s00_axi_awaddr_i  (s00_axi_awaddr_i),
        .s00_axi_awvalid_i (s00_axi_awvalid_i),
        .s00_axi_awready_o (s00_axi_awready_o),
        .s00_axi_wdata_i   (s00_axi_wdata_i),
        .s00_axi_wvalid_i  (s00_axi_wvalid_i),
        .s00_axi_wready_o  (s00_axi_wready_o),
        .s00_axi_bresp_o   (s00_axi_bresp_o),
        .s00_axi_bvalid_o  (s00_axi_bvalid_o),
        .s00_axi_bready_i  (s00_axi_bready_i),
        .s00_axi_araddr_i  (s00_axi_araddr_i),
        .s00_axi_arvalid_i (s00_axi_arvalid_i),
        .s00_axi_arready_o (s00_axi_arready_o),
        .s00_axi_rdata_o   (s00_axi_rdata_o),
        .s00_axi_rresp_o   (s00_axi_rresp_o),
        .s00_axi_rvalid_o  (s00_axi_rvalid_o),
        .s00_axi_rready_i  (s00_axi_rready_i),
        .clk_div_o         (div_r),
        .argument_o        (arg_r),
        .cmd_index_o       (idx_r),
        .resp_en_o         (resp_en_r),
        .timeout_o         (timeout_r),
        .cmd_start_o       (cmd_start),
        .interrupt_o       (interrupt_o),
        .cmd_inhibit_i     (cmd_inhibit),
        .int_set_i         (int_set),
        .response_we_i     (response_we),
        .response_i        (response)
    );

    // SD clock divider
    assign rise_evt = (div_cnt >= div_r) && !sd_clk_o;
    assign fall_evt = (div_cnt >= div_r) && sd_clk_o;

    always_ff @(posedge s00_axi_aclk) begin
        if (reset_i) begin
            div_cnt  <= '0;
            sd_clk_o <= 1'b0;
        end else if (div_cnt >= div_r) begin
            div_cnt  <= '0;
            sd_clk_o <= ~sd_clk_o;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    sd_cmd_tx u_tx (
        .s00_axi_aclk (s00_axi_aclk),
        .reset_i      (reset_i),
        .fall_evt_i   (fall_evt),
        .start_i      (tx_start),
        .frame_i      (tx_frame),
        .sd_cmd_o     (sd_cmd_o),
        .sd_cmd_t_o   (sd_cmd_t_o),
        .done_o       (tx_done)
    );

    // command engine
    always_ff @(posedge s00_axi_aclk) begin
        logic [39:0] hdr;
        logic [sd_pkg::INT_CMD_W-1:0] flags;
        if (reset_i) begin
            state       <= S_IDLE;
            tx_start    <= 1'b0;
            tx_frame    <= '0;
            rx_sh       <= '0;
            rcnt        <= '0;
            tcnt        <= '0;
            int_set     <= '0;
            response_we <= 1'b0;
            response    <= '0;
        end else begin
            flags = '0;
            tx_start    <= 1'b0;
            response_we <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_start) begin
                        hdr = {1'b0, 1'b1, idx_r, arg_r};
                        tx_frame <= {hdr, sd_pkg::crc7(hdr), 1'b1};
                        tx_start <= 1'b1;
                        state    <= S_TX;
                    end
                end
                S_TX: begin
                    if (tx_done) begin
                        if (resp_en_r) begin
                            state <= S_RX_WAIT;
                            tcnt  <= '0;
                        end else begin
                            flags[sd_pkg::INT_CMD_DONE] = 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                S_RX_WAIT: begin
                    if (rise_evt) begin
                        if (!sd_cmd_i) begin
                            rx_sh <= '0;
                            rcnt  <= 6'd1;
                            state <= S_RX;
                        end else if (tcnt >= timeout_r) begin
                            flags[sd_pkg::INT_CMD_TIMEOUT] = 1'b1;
                            state <= S_IDLE;
                        end else begin
                            tcnt <= tcnt + 1'b1;
                        end
                    end
                end
                S_RX: begin
                    if (rise_evt) begin
                        rx_sh <= {rx_sh[46:0], sd_cmd_i};
                        rcnt  <= rcnt + 6'd1;
                        if (rcnt == 6'd47) begin
                            state <= S_CHECK;
                        end
                    end
                end
                S_CHECK: begin
                    response    <= rx_sh[39:8];
                    response_we <= 1'b1;
                    // bad CRC or missing end bit
                    if (sd_pkg::crc7(rx_sh[47:8]) != rx_sh[7:1] || !rx_sh[0]) begin
                        flags[sd_pkg::INT_CMD_CRC] = 1'b1;
                    end
                    if (rx_sh[45:40] != idx_r) begin
                        flags[sd_pkg::INT_CMD_INDEX] = 1'b1;
                    end
                    flags[sd_pkg::INT_CMD_DONE] = 1'b1;
                    state <= S_IDLE;
                end
                default: ;
            endcase
            int_set <= flags;
        end
    end

endmodule

`default_nettype wire

//--- sd_cmd_sva.sv
`timescale 1ns/1ps
`default_nettype none

// bound twice, inputs unused at a bind are tied to their idle level
module sd_cmd_sva (
    input wire clk_i,
    input wire reset_i,
    input wire cmd_t_i,
    input wire cmd_i,
    input wire bvalid_i,
    input wire bready_i,
    input wire rvalid_i,
    input wire rready_i
);

    // host releases the line only after driving the end bit
    assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(cmd_t_i) |-> $past(cmd_i))
        else $error("command line released before the end bit");

    assert property (@(posedge clk_i) disable iff (reset_i)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid dropped before rready");

endmodule

bind sd_cmd_tx sd_cmd_sva cmd_line_sva (
    .clk_i    (s00_axi_aclk),
    .reset_i  (reset_i),
    .cmd_t_i  (sd_cmd_t_o),
    .cmd_i    (sd_cmd_o),
    .bvalid_i (1'b0),
    .bready_i (1'b0),
    .rvalid_i (1'b0),
    .rready_i (1'b0)
);

bind sd_axil_regs sd_cmd_sva axi_resp_sva (
    .clk_i    (s00_axi_aclk),
    .reset_i  (reset_i),
    .cmd_t_i  (1'b0),
    .cmd_i    (1'b1),
    .bvalid_i (s00_axi_bvalid_o),
    .bready_i (s00_axi_bready_i),
    .rvalid_i (s00_axi_rvalid_o),
    .rready_i (s00_axi_rready_i)
);

`default_nettype wire

//--- tb_sd_emmc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_emmc_controller;

    typedef enum int {CARD_GOOD, CARD_BAD_CRC, CARD_BAD_INDEX, CARD_SILENT} card_mode_t;

    logic        aclk;
    logic        reset_i;
    logic [6:0]  s00_axi_awaddr;
    logic        s00_axi_awvalid;
    logic        s00_axi_awready;
    logic [31:0] s00_axi_wdata;
    logic        s00_axi_wvalid;
    logic        s00_axi_wready;
    logic [1:0]  s00_axi_bresp;
    logic        s00_axi_bvalid;
    logic        s00_axi_bready;
    logic [6:0]  s00_axi_araddr;
    logic        s00_axi_arvalid;
    logic        s00_axi_arready;
    logic [31:0] s00_axi_rdata;
    logic [1:0]  s00_axi_rresp;
    logic        s00_axi_rvalid;
    logic        s00_axi_rready;
    logic        sd_clk;
    logic        sd_cmd_host;
    logic        sd_cmd_t;
    logic        sd_cmd_card;
    logic        interrupt;

    // divisor and response timeout used by the command tests
    int unsigned sd_div_used = 1;
    int unsigned resp_timeout = 100;

    logic [15:0] lfsr_state = 16'd64407;

    // card model state, set per test
    card_mode_t  card_mode = CARD_SILENT;
    logic [31:0] card_arg = '0;
    logic [47:0] card_frame = '0;

    // pending checks for the compare process
    string       name_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] act_q[$];
    int          checks_queued = 0;
    int          checks_done = 0;

    string       test_name = "";
    int          test_errors = 0;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    sd_emmc_controller dut (
        .s00_axi_aclk      (aclk),
        .reset_i           (reset_i),
        .s00_axi_awaddr_i  (s00_axi_awaddr),
        .s00_axi_awvalid_i (s00_axi_awvalid),
        .s00_axi_awready_o (s00_axi_awready),
        .s00_axi_wdata_i   (s00_axi_wdata),
        .s00_axi_wvalid_i  (s00_axi_wvalid),
        .s00_axi_wready_o  (s00_axi_wready),
        .s00_axi_bresp_o   (s00_axi_bresp),
        .s00_axi_bvalid_o  (s00_axi_bvalid),
        .s00_axi_bready_i  (s00_axi_bready),
        .s00_axi_araddr_i  (s00_axi_araddr),
        .s00_axi_arvalid_i (s00_axi_arvalid),
        .s00_axi_arready_o (s00_axi_arready),
        .s00_axi_rdata_o   (s00_axi_rdata),
        .s00_axi_rresp_o   (s00_axi_rresp),
        .s00_axi_rvalid_o  (s00_axi_rvalid),
        .s00_axi_rready_i  (s00_axi_rready),
        .sd_clk_o          (sd_clk),
        .sd_cmd_o          (sd_cmd_host),
        .sd_cmd_t_o        (sd_cmd_t),
        .sd_cmd_i          (sd_cmd_card),
        .interrupt_o       (interrupt)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // CRC7 x^7 + x^3 + 1, bit serial from zero
    function automatic logic [6:0] compute_crc7(input logic [39:0] bits);
        logic [6:0] r;
        logic inv;
        r = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            inv = bits[i] ^ r[6];
            r[6] = r[5];
            r[5] = r[4];
            r[4] = r[3];
            r[3] = r[2] ^ inv;
            r[2] = r[1];
            r[1] = r[0];
            r[0] = inv;
        end
        return r;
    endfunction

    // expected host frame, status bits and response for one command
    function automatic void reference_model(
        input  logic [5:0]  index,
        input  logic [31:0] arg,
        input  logic        resp_en,
        input  card_mode_t  mode,
        input  logic [31:0] card_word,
        output logic [47:0] frame,
        output logic [31:0] status,
        output logic [31:0] response
    );
        logic [39:0] header;
        header = {1'b0, 1'b1, index, arg};
        frame = {header, compute_crc7(header), 1'b1};
        response = card_word;
        status = '0;
        if (resp_en && mode == CARD_SILENT) begin
            status[sd_pkg::INT_CMD_TIMEOUT] = 1'b1;
        end else begin
            status[sd_pkg::INT_CMD_DONE] = 1'b1;
            if (resp_en && mode == CARD_BAD_CRC) begin
                status[sd_pkg::INT_CMD_CRC] = 1'b1;
            end
            if (resp_en && mode == CARD_BAD_INDEX) begin
                status[sd_pkg::INT_CMD_INDEX] = 1'b1;
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic expect_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        name_q.push_back({test_name, "/", what});
        exp_q.push_back(expected);
        act_q.push_back(actual);
        checks_queued++;
    endtask

    initial begin : compare_proc
        string what;
        logic [63:0] e;
        logic [63:0] a;
        forever begin
            wait (checks_queued > checks_done);
            what = name_q.pop_front();
            e = exp_q.pop_front();
            a = act_q.pop_front();
            check_value(what, e, a);
            checks_done++;
        end
    end

    task automatic finish_test();
        wait (checks_done == checks_queued);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: fail, %0d mismatches", test_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic axi_write(input logic [6:0] addr, input logic [31:0] data);
        @(posedge aclk);
        #1;
        s00_axi_awaddr = addr;
        s00_axi_wdata = data;
        s00_axi_awvalid = 1'b1;
        s00_axi_wvalid = 1'b1;
        s00_axi_bready = 1'b0;
        do begin
            @(posedge aclk);
            #1;
        end while (!s00_axi_awready);
        expect_value("wready", 1'b1, s00_axi_wready);
        @(posedge aclk);
        #1;
        s00_axi_awvalid = 1'b0;
        s00_axi_wvalid = 1'b0;
        while (!s00_axi_bvalid) begin
            @(posedge aclk);
            #1;
        end
        expect_value("bresp", 2'b00, s00_axi_bresp);
        // hold bready low one cycle so bvalid must wait
        @(posedge aclk);
        #1;
        s00_axi_bready = 1'b1;
        @(posedge aclk);
        #1;
        s00_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [6:0] addr, output logic [31:0] data);
        @(posedge aclk);
        #1;
        s00_axi_araddr = addr;
        s00_axi_arvalid = 1'b1;
        s00_axi_rready = 1'b0;
        do begin
            @(posedge aclk);
            #1;
        end while (!s00_axi_arready);
        @(posedge aclk);
        #1;
        s00_axi_arvalid = 1'b0;
        while (!s00_axi_rvalid) begin
            @(posedge aclk);
            #1;
        end
        data = s00_axi_rdata;
        expect_value("rresp", 2'b00, s00_axi_rresp);
        // hold rready low one cycle so rvalid must wait
        @(posedge aclk);
        #1;
        s00_axi_rready = 1'b1;
        @(posedge aclk);
        #1;
        s00_axi_rready = 1'b0;
    endtask

    task automatic write_readback(input string what, input logic [6:0] addr,
                                  input logic [31:0] value);
        logic [31:0] rd;
        axi_write(addr, value);
        axi_read(addr, rd);
        expect_value(what, value, rd);
    endtask

    // poll until the command reports done or timeout
    task automatic wait_command_end(output logic [31:0] status);
        status = '0;
        while (!status[sd_pkg::INT_CMD_DONE] && !status[sd_pkg::INT_CMD_TIMEOUT]) begin
            axi_read(sd_pkg::REG_INT_STATUS, status);
        end
    endtask

    task automatic run_command(input string name, input logic resp_en,
                               input card_mode_t mode, input bit clear_status);
        logic [31:0] bits;
        logic [31:0] arg;
        logic [31:0] rd;
        logic [5:0]  index;
        logic [47:0] exp_frame;
        logic [31:0] exp_status;
        logic [31:0] exp_resp;
        test_name = name;
        take_bits(6, bits);
        index = bits[5:0];
        take_bits(32, arg);
        take_bits(32, card_arg);
        card_mode = mode;
        reference_model(index, arg, resp_en, mode, card_arg, exp_frame, exp_status, exp_resp);
        axi_write(sd_pkg::REG_ARGUMENT, arg);
        axi_write(sd_pkg::REG_COMMAND, (32'(resp_en) << sd_pkg::RESP_EN_BIT) | 32'(index));
        axi_read(sd_pkg::REG_PRESENT, rd);
        expect_value("inhibit busy", 1'b1, rd[0]);
        wait_command_end(rd);
        expect_value("status", exp_status, rd);
        // let the card finish sampling the end bit
        repeat (2) @(posedge sd_clk);
        #1;
        expect_value("frame", exp_frame, card_frame);
        if (resp_en && mode != CARD_SILENT) begin
            axi_read(sd_pkg::REG_RESPONSE, rd);
            expect_value("response", exp_resp, rd);
        end
        axi_read(sd_pkg::REG_PRESENT, rd);
        expect_value("inhibit idle", 1'b0, rd[0]);
        if (clear_status) begin
            axi_write(sd_pkg::REG_INT_STATUS, exp_status);
            axi_read(sd_pkg::REG_INT_STATUS, rd);
            expect_value("status cleared", 0, rd);
        end
        finish_test();
    endtask

    // card: capture host frame on SD_CLK rise, answer two periods later
    initial begin : card_model
        logic [47:0] rx_bits;
        logic [47:0] resp;
        logic [39:0] hdr;
        logic [5:0]  idx;
        sd_cmd_card = 1'b1;
        forever begin
            @(posedge sd_clk);
            #1;
            if (sd_cmd_t && !sd_cmd_host) begin
                rx_bits = 48'd0;
                repeat (47) begin
                    @(posedge sd_clk);
                    #1;
                    rx_bits = {rx_bits[46:0], sd_cmd_host};
                end
                card_frame = rx_bits;
                if (card_mode != CARD_SILENT) begin
                    repeat (2) @(posedge sd_clk);
                    idx = rx_bits[45:40];
                    if (card_mode == CARD_BAD_INDEX) begin
                        idx = idx ^ 6'h01;
                    end
                    hdr = {2'b00, idx, card_arg};
                    resp = {hdr, compute_crc7(hdr), 1'b1};
                    if (card_mode == CARD_BAD_CRC) begin
                        resp[7:1] = ~resp[7:1];
                    end
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge sd_clk);
                        #1;
                        sd_cmd_card = resp[i];
                    end
                    @(negedge sd_clk);
                    #1;
                    sd_cmd_card = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        int unsigned cycles;
        // 6 commands of 48 bits out plus the longer of reply or timeout, plus AXI traffic
        limit = 6 * (48 + resp_timeout + 50) * 2 * (sd_div_used + 1) + 3000;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", limit);
        $display("tests failed");
        $finish;
    end

    initial begin : main
        logic [31:0] value;
        logic [31:0] rd;
        reset_i = 1'b1;
        s00_axi_awaddr = '0;
        s00_axi_awvalid = 1'b0;
        s00_axi_wdata = '0;
        s00_axi_wvalid = 1'b0;
        s00_axi_bready = 1'b0;
        s00_axi_araddr = '0;
        s00_axi_arvalid = 1'b0;
        s00_axi_rready = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        reset_i = 1'b0;

        test_name = "reg_rw";
        expect_value("irq after reset", 1'b0, interrupt);
        axi_read(sd_pkg::REG_INT_STATUS, rd);
        expect_value("status after reset", 0, rd);
        take_bits(32, value);
        write_readback("argument", sd_pkg::REG_ARGUMENT, value);
        take_bits(sd_pkg::INT_CMD_W, value);
        write_readback("int enable", sd_pkg::REG_INT_ENABLE, value);
        take_bits(sd_pkg::CLK_DIV_W, value);
        write_readback("clk div", sd_pkg::REG_CLK_DIV, value);
        take_bits(sd_pkg::CMD_TIMEOUT_W, value);
        write_readback("timeout", sd_pkg::REG_TIMEOUT, value);
        axi_read(7'h24, rd);
        expect_value("unmapped", 0, rd);
        finish_test();

        axi_write(sd_pkg::REG_CLK_DIV, sd_div_used);
        axi_write(sd_pkg::REG_TIMEOUT, resp_timeout);
        axi_write(sd_pkg::REG_INT_ENABLE, 0);

        run_command("cmd_no_resp", 1'b0, CARD_SILENT, 1'b1);
        run_command("cmd_good", 1'b1, CARD_GOOD, 1'b1);
        run_command("cmd_bad_crc", 1'b1, CARD_BAD_CRC, 1'b1);
        run_command("cmd_bad_index", 1'b1, CARD_BAD_INDEX, 1'b1);
        run_command("cmd_silent", 1'b1, CARD_SILENT, 1'b1);
        // leave DONE pending for the interrupt test
        run_command("irq_cmd", 1'b1, CARD_GOOD, 1'b0);

        test_name = "interrupt";
        repeat (2) @(posedge aclk);
        #1;
        expect_value("irq masked", 1'b0, interrupt);
        axi_write(sd_pkg::REG_INT_ENABLE, 32'd1 << sd_pkg::INT_CMD_DONE);
        repeat (2) @(posedge aclk);
        #1;
        expect_value("irq enabled", 1'b1, interrupt);
        axi_write(sd_pkg::REG_INT_STATUS, 32'd1 << sd_pkg::INT_CMD_DONE);
        repeat (2) @(posedge aclk);
        #1;
        expect_value("irq cleared", 1'b0, interrupt);
        finish_test();

        $display("%0d tests run, %0d ok, %0d with errors, %0d mismatches",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
sd_pkg.sv
sd_axil_regs.sv
sd_emmc_controller.sv
sd_cmd_sva.sv
tb_sd_emmc_controller.sv

//--- Makefile
# Verilator build and run for the SD command-path testbench

VERILATOR ?= verilator
TOP       ?= tb_sd_emmc_controller
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
